// ==== verilog/sq_settings.svh ====
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// Queue geometry
`define SQ_DEPTH 8
`define SQ_IDX_W 3

// Dispatch lanes from the decoder
`define SQ_DISPATCH_W 2

// Store functional units that deliver address and data
`define SQ_STORE_FU 2

// Load ports that query for forwarding
`define SQ_LOAD_PORTS 2

// Write ports into the data cache
`define SQ_CACHE_PORTS 2

// Address and data width of the core
`define SQ_XLEN 32

`endif

// ==== verilog/sq_pkg.sv ====
`default_nettype none

`include "sq_settings.svh"

package sq_pkg;

    // Encodings follow the RISC-V funct3 field of loads and stores
    typedef enum logic [2:0] {
        BYTE  = 3'b000,
        HALF  = 3'b001,
        WORD  = 3'b010,
        BYTEU = 3'b100,
        HALFU = 3'b101
    } mem_func_e;

    // DRAIN_ONLY while almost-full is holding off dispatch
    typedef enum logic {
        RUN        = 1'b0,
        DRAIN_ONLY = 1'b1
    } ctrl_state_e;

    typedef logic [`SQ_IDX_W-1:0] sq_idx_t;

    typedef struct packed {
        logic                valid;
        mem_func_e           func;
        logic [`SQ_XLEN-1:0] addr;
        logic [`SQ_XLEN-1:0] data;
        logic                ready;
    } sq_entry_t;

    // One per dispatch lane from the decoder
    typedef struct packed {
        logic      valid;
        mem_func_e func;
    } id_sq_packet_t;

    // One-cycle strobe from a store unit
    typedef struct packed {
        logic                valid;
        logic [`SQ_XLEN-1:0] base;
        logic [11:0]         imm;
        logic [`SQ_XLEN-1:0] data;
        sq_idx_t             sq_idx;
    } rs_sq_packet_t;

    typedef struct packed {
        logic                valid;
        logic [`SQ_XLEN-1:0] addr;
        mem_func_e           func;
        logic [`SQ_XLEN-1:0] data;
    } sq_dcache_packet_t;

    // youngest_older is the tail seen when the load dispatched
    typedef struct packed {
        logic [`SQ_XLEN-1:0] addr;
        mem_func_e           func;
        sq_idx_t             youngest_older;
    } ld_query_t;

    typedef struct packed {
        logic                hit;
        logic [`SQ_XLEN-1:0] value;
    } fwd_result_t;

endpackage

`default_nettype wire

// ==== verilog/sq_control.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sq_settings.svh"

module sq_control (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [`SQ_DISPATCH_W-1:0]             id_valid,
    input  logic [1:0]                            commit_count,
    input  logic [1:0]                            sent_count,
    input  logic [`SQ_DEPTH-1:0]                  ready_vec,
    output logic [`SQ_DISPATCH_W-1:0]             alloc_en,
    output sq_pkg::sq_idx_t [`SQ_DISPATCH_W-1:0]  alloc_idx,
    output sq_pkg::sq_idx_t                       head,
    output sq_pkg::sq_idx_t                       tail,
    output sq_pkg::sq_idx_t                       ready_tail,
    output logic [`SQ_IDX_W:0]                    credit,
    output logic                                  almost_full
);

    logic [`SQ_IDX_W:0]  size;
    logic [`SQ_IDX_W:0]  size_next;
    logic [`SQ_IDX_W:0]  credit_next;
    logic [1:0]          n_alloc;
    sq_pkg::ctrl_state_e state;
    sq_pkg::ctrl_state_e state_next;

    assign almost_full = (state == sq_pkg::DRAIN_ONLY);

    // Accepted lanes take consecutive slots from tail
    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < `SQ_DISPATCH_W; i++) begin
            alloc_en[i]  = id_valid[i] && !almost_full;
            alloc_idx[i] = tail + sq_pkg::sq_idx_t'(n_alloc);
            if (alloc_en[i]) begin
                n_alloc = n_alloc + 2'd1;
            end
        end
    end

    always_comb begin
        size_next   = size + (`SQ_IDX_W+1)'(n_alloc) - (`SQ_IDX_W+1)'(sent_count);
        credit_next = credit + (`SQ_IDX_W+1)'(commit_count) - (`SQ_IDX_W+1)'(sent_count);
        // Keep room for a full dispatch group at all times
        if (size_next > (`SQ_IDX_W+1)'(`SQ_DEPTH - `SQ_DISPATCH_W)) begin
            state_next = sq_pkg::DRAIN_ONLY;
        end else begin
            state_next = sq_pkg::RUN;
        end
    end

    // Length of the ready run starting at head
    always_comb begin
        logic               run;
        logic [`SQ_IDX_W:0] count;
        run   = 1'b1;
        count = '0;
        for (int j = 0; j < `SQ_DEPTH; j++) begin
            run = run && ready_vec[head + sq_pkg::sq_idx_t'(j)];
            if (run) begin
                count = count + 1'b1;
            end
        end
        ready_tail = head + sq_pkg::sq_idx_t'(count);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            size   <= '0;
            credit <= '0;
            state  <= sq_pkg::RUN;
        end else begin
            head   <= head + sq_pkg::sq_idx_t'(sent_count);
            tail   <= tail + sq_pkg::sq_idx_t'(n_alloc);
            size   <= size_next;
            credit <= credit_next;
            state  <= state_next;
        end
    end

    assert property (@(posedge clock) disable iff (reset) size <= `SQ_DEPTH);

    // The drain must never send a store the reorder buffer has not retired
    assert property (@(posedge clock) disable iff (reset)
        (`SQ_IDX_W+1)'(sent_count) <= credit);

endmodule

`default_nettype wire

// ==== verilog/sq_entry_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sq_settings.svh"

module sq_entry_file (
    input  logic                                       clock,
    input  logic                                       reset,
    input  sq_pkg::id_sq_packet_t [`SQ_DISPATCH_W-1:0] id_sq_packet,
    input  logic [`SQ_DISPATCH_W-1:0]                  alloc_en,
    input  sq_pkg::sq_idx_t [`SQ_DISPATCH_W-1:0]       alloc_idx,
    input  sq_pkg::rs_sq_packet_t [`SQ_STORE_FU-1:0]   rs_sq_packet,
    input  logic [`SQ_DEPTH-1:0]                       clear_en,
    output sq_pkg::sq_entry_t [`SQ_DEPTH-1:0]          entries,
    output logic [`SQ_DEPTH-1:0]                       ready_vec
);

    typedef struct packed {
        sq_pkg::sq_idx_t     idx;
        logic [`SQ_XLEN-1:0] addr;
        logic [`SQ_XLEN-1:0] data;
    } fill_t;

    logic [`SQ_DEPTH-1:0]     valid_q;
    logic [`SQ_DEPTH-1:0]     ready_q;
    sq_pkg::mem_func_e        func_q [`SQ_DEPTH];
    logic [`SQ_XLEN-1:0]      addr_q [`SQ_DEPTH];
    logic [`SQ_XLEN-1:0]      data_q [`SQ_DEPTH];
    logic [`SQ_STORE_FU-1:0]  fill_valid_q;
    fill_t [`SQ_STORE_FU-1:0] fill_q;
    logic [`SQ_DEPTH-1:0]     alloc_mask;
    logic [`SQ_DEPTH-1:0]     fill_mask;

    always_comb begin
        alloc_mask = '0;
        fill_mask  = '0;
        for (int i = 0; i < `SQ_DISPATCH_W; i++) begin
            if (alloc_en[i]) begin
                alloc_mask[alloc_idx[i]] = 1'b1;
            end
        end
        for (int f = 0; f < `SQ_STORE_FU; f++) begin
            if (fill_valid_q[f]) begin
                fill_mask[fill_q[f].idx] = 1'b1;
            end
        end
    end

    // Address generation stage adds the sign-extended immediate to base
    always_ff @(posedge clock) begin
        if (reset) begin
            fill_valid_q <= '0;
        end else begin
            for (int f = 0; f < `SQ_STORE_FU; f++) begin
                fill_valid_q[f] <= rs_sq_packet[f].valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int f = 0; f < `SQ_STORE_FU; f++) begin
            fill_q[f].idx  <= rs_sq_packet[f].sq_idx;
            fill_q[f].addr <= rs_sq_packet[f].base
                              + {{20{rs_sq_packet[f].imm[11]}}, rs_sq_packet[f].imm};
            fill_q[f].data <= rs_sq_packet[f].data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            valid_q <= (valid_q & ~clear_en) | alloc_mask;
            ready_q <= (ready_q & ~clear_en & ~alloc_mask) | fill_mask;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `SQ_DISPATCH_W; i++) begin
            if (alloc_en[i]) begin
                func_q[alloc_idx[i]] <= id_sq_packet[i].func;
            end
        end
        for (int f = 0; f < `SQ_STORE_FU; f++) begin
            if (fill_valid_q[f]) begin
                addr_q[fill_q[f].idx] <= fill_q[f].addr;
                data_q[fill_q[f].idx] <= fill_q[f].data;
            end
        end
    end

    always_comb begin
        for (int e = 0; e < `SQ_DEPTH; e++) begin
            entries[e].valid = valid_q[e];
            entries[e].func  = func_q[e];
            entries[e].addr  = addr_q[e];
            entries[e].data  = data_q[e];
            entries[e].ready = ready_q[e];
        end
        ready_vec = valid_q & ready_q;
    end

    // Store units may only name slots the decoder has allocated
    for (genvar f = 0; f < `SQ_STORE_FU; f++) begin : g_fill_check
        assert property (@(posedge clock) disable iff (reset)
            fill_valid_q[f] |-> valid_q[fill_q[f].idx]);
    end

    assert property (@(posedge clock) disable iff (reset) (clear_en & alloc_mask) == '0);

endmodule

`default_nettype wire

// ==== verilog/sq_drain.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sq_settings.svh"

module sq_drain (
    input  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0]                entries,
    input  sq_pkg::sq_idx_t                                  head,
    input  logic [`SQ_IDX_W:0]                               credit,
    input  logic [`SQ_CACHE_PORTS-1:0]                       dcache_accept,
    output sq_pkg::sq_dcache_packet_t [`SQ_CACHE_PORTS-1:0]  sq_dcache_packet,
    output logic [`SQ_DEPTH-1:0]                             clear_en,
    output logic [1:0]                                       sent_count
);

    // Port k carries the entry k places after head
    always_comb begin
        sq_pkg::sq_idx_t idx;
        logic            present;
        logic            firing;
        sq_dcache_packet = '0;
        clear_en         = '0;
        sent_count       = '0;
        present          = 1'b1;
        firing           = 1'b1;
        for (int k = 0; k < `SQ_CACHE_PORTS; k++) begin
            idx = head + sq_pkg::sq_idx_t'(k);
            // Stop at the first store not yet ready or not yet retired
            present = present
                      && entries[idx].valid
                      && entries[idx].ready
                      && (credit > (`SQ_IDX_W+1)'(k));
            if (present) begin
                sq_dcache_packet[k].valid = 1'b1;
                sq_dcache_packet[k].addr  = entries[idx].addr;
                sq_dcache_packet[k].func  = entries[idx].func;
                sq_dcache_packet[k].data  = entries[idx].data;
            end
            // A port fires only behind firing ports
            firing = firing && present && dcache_accept[k];
            if (firing) begin
                clear_en[idx] = 1'b1;
                sent_count    = sent_count + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sq_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sq_settings.svh"

module sq_forward (
    input  sq_pkg::sq_entry_t [`SQ_DEPTH-1:0]       entries,
    input  sq_pkg::sq_idx_t                         head,
    input  sq_pkg::ld_query_t [`SQ_LOAD_PORTS-1:0]  ld_query,
    output sq_pkg::fwd_result_t [`SQ_LOAD_PORTS-1:0] fwd_result
);

    // Bytes touched within the aligned word
    function automatic logic [3:0] byte_mask(sq_pkg::mem_func_e func, logic [1:0] offset);
        logic [3:0] base_mask;
        case (func)
            sq_pkg::BYTE, sq_pkg::BYTEU: base_mask = 4'b0001;
            sq_pkg::HALF, sq_pkg::HALFU: base_mask = 4'b0011;
            default:                     base_mask = 4'b1111;
        endcase
        return base_mask << offset;
    endfunction

    function automatic logic [`SQ_XLEN-1:0] extend(logic [`SQ_XLEN-1:0] raw,
                                                   sq_pkg::mem_func_e func);
        case (func)
            sq_pkg::BYTE:  return {{24{raw[7]}}, raw[7:0]};
            sq_pkg::BYTEU: return {24'h0, raw[7:0]};
            sq_pkg::HALF:  return {{16{raw[15]}}, raw[15:0]};
            sq_pkg::HALFU: return {16'h0, raw[15:0]};
            default:       return raw;
        endcase
    endfunction

    always_comb begin
        sq_pkg::sq_idx_t     idx;
        sq_pkg::sq_idx_t     match_idx;
        logic                stop;
        logic                found;
        logic                overlap;
        logic [3:0]          load_mask;
        logic [3:0]          store_mask;
        logic [3:0]          match_mask;
        logic [`SQ_XLEN-1:0] mem_word;
        logic [`SQ_XLEN-1:0] raw;
        for (int p = 0; p < `SQ_LOAD_PORTS; p++) begin
            load_mask  = byte_mask(ld_query[p].func, ld_query[p].addr[1:0]);
            stop       = 1'b0;
            found      = 1'b0;
            match_idx  = head;
            match_mask = '0;
            // Scanning oldest to youngest leaves the youngest match last
            for (int j = 0; j < `SQ_DEPTH; j++) begin
                idx  = head + sq_pkg::sq_idx_t'(j);
                stop = stop || (idx == ld_query[p].youngest_older);
                store_mask = byte_mask(entries[idx].func, entries[idx].addr[1:0]);
                overlap = (entries[idx].addr[`SQ_XLEN-1:2] == ld_query[p].addr[`SQ_XLEN-1:2])
                          && |(store_mask & load_mask);
                // A store without its address yet might alias anything
                if (!stop && entries[idx].valid && (!entries[idx].ready || overlap)) begin
                    found      = 1'b1;
                    match_idx  = idx;
                    match_mask = store_mask;
                end
            end
            mem_word = entries[match_idx].data << {entries[match_idx].addr[1:0], 3'b000};
            raw      = mem_word >> {ld_query[p].addr[1:0], 3'b000};
            fwd_result[p].hit = found
                                && entries[match_idx].ready
                                && ((load_mask & ~match_mask) == 4'b0000);
            fwd_result[p].value = fwd_result[p].hit ? extend(raw, ld_query[p].func) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/store_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sq_settings.svh"

module store_queue (
    input  logic                                           clock,
    input  logic                                           reset,
    // Decoder
    input  sq_pkg::id_sq_packet_t [`SQ_DISPATCH_W-1:0]     id_sq_packet,
    output logic                                           almost_full,
    output sq_pkg::sq_idx_t                                tail,
    // Store units
    input  sq_pkg::rs_sq_packet_t [`SQ_STORE_FU-1:0]       rs_sq_packet,
    // Reorder buffer
    input  logic [1:0]                                     commit_count,
    output logic [1:0]                                     sent_count,
    // Data cache
    output sq_pkg::sq_dcache_packet_t [`SQ_CACHE_PORTS-1:0] sq_dcache_packet,
    input  logic [`SQ_CACHE_PORTS-1:0]                     dcache_accept,
    // Load ports answered in the same cycle
    input  sq_pkg::ld_query_t [`SQ_LOAD_PORTS-1:0]         ld_query,
    output sq_pkg::fwd_result_t [`SQ_LOAD_PORTS-1:0]       fwd_result,
    output sq_pkg::sq_idx_t                                head,
    output sq_pkg::sq_idx_t                                ready_tail
);

    logic [`SQ_DISPATCH_W-1:0]              id_valid;
    logic [`SQ_DISPATCH_W-1:0]              alloc_en;
    sq_pkg::sq_idx_t [`SQ_DISPATCH_W-1:0]   alloc_idx;
    logic [`SQ_DEPTH-1:0]                   ready_vec;
    logic [`SQ_DEPTH-1:0]                   clear_en;
    logic [`SQ_IDX_W:0]                     credit;
    sq_pkg::sq_entry_t [`SQ_DEPTH-1:0]      entries;

    always_comb begin
        for (int i = 0; i < `SQ_DISPATCH_W; i++) begin
            id_valid[i] = id_sq_packet[i].valid;
        end
    end

    sq_control sq_control_i (
        .clock        (clock),
        .reset        (reset),
        .id_valid     (id_valid),
        .commit_count (commit_count),
        .sent_count   (sent_count),
        .ready_vec    (ready_vec),
        .alloc_en     (alloc_en),
        .alloc_idx    (alloc_idx),
        .head         (head),
        .tail         (tail),
        .ready_tail   (ready_tail),
        .credit       (credit),
        .almost_full  (almost_full)
    );

    sq_entry_file sq_entry_file_i (
        .clock        (clock),
        .reset        (reset),
        .id_sq_packet (id_sq_packet),
        .alloc_en     (alloc_en),
        .alloc_idx    (alloc_idx),
        .rs_sq_packet (rs_sq_packet),
        .clear_en     (clear_en),
        .entries      (entries),
        .ready_vec    (ready_vec)
    );

    sq_drain sq_drain_i (
        .entries          (entries),
        .head             (head),
        .credit           (credit),
        .dcache_accept    (dcache_accept),
        .sq_dcache_packet (sq_dcache_packet),
        .clear_en         (clear_en),
        .sent_count       (sent_count)
    );

    sq_forward sq_forward_i (
        .entries    (entries),
        .head       (head),
        .ld_query   (ld_query),
        .fwd_result (fwd_result)
    );

endmodule

`default_nettype wire

// ==== test/store_queue_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sq_settings.svh"

module store_queue_tb;

    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_CYCLES = 16;
    localparam int PERIOD_NS    = 4;

    logic                                            clock;
    logic                                            reset;
    sq_pkg::id_sq_packet_t [`SQ_DISPATCH_W-1:0]      id_sq_packet;
    logic                                            almost_full;
    sq_pkg::sq_idx_t                                 tail;
    sq_pkg::rs_sq_packet_t [`SQ_STORE_FU-1:0]        rs_sq_packet;
    logic [1:0]                                      commit_count;
    logic [1:0]                                      sent_count;
    sq_pkg::sq_dcache_packet_t [`SQ_CACHE_PORTS-1:0] sq_dcache_packet;
    logic [`SQ_CACHE_PORTS-1:0]                      dcache_accept;
    sq_pkg::ld_query_t [`SQ_LOAD_PORTS-1:0]          ld_query;
    sq_pkg::fwd_result_t [`SQ_LOAD_PORTS-1:0]        fwd_result;
    sq_pkg::sq_idx_t                                 head;
    sq_pkg::sq_idx_t                                 ready_tail;

    // Reference model of the queue
    logic [`SQ_DEPTH-1:0] m_valid;
    logic [`SQ_DEPTH-1:0] m_ready;
    sq_pkg::mem_func_e    m_func [`SQ_DEPTH];
    logic [31:0]          m_addr [`SQ_DEPTH];
    logic [31:0]          m_data [`SQ_DEPTH];
    sq_pkg::sq_idx_t      m_head;
    sq_pkg::sq_idx_t      m_tail;
    int                   m_size;
    int                   m_credit;
    logic                 m_af;
    // Fills in the address generation stage
    logic [`SQ_STORE_FU-1:0] p_valid;
    sq_pkg::sq_idx_t         p_idx [`SQ_STORE_FU];
    logic [31:0]             p_addr [`SQ_STORE_FU];
    logic [31:0]             p_data [`SQ_STORE_FU];
    // Allocated slots still waiting for their store unit
    sq_pkg::sq_idx_t         unfilled [$];

    logic [31:0] lcg_state;
    int          errors;

    store_queue store_queue_i (
        .clock            (clock),
        .reset            (reset),
        .id_sq_packet     (id_sq_packet),
        .almost_full      (almost_full),
        .tail             (tail),
        .rs_sq_packet     (rs_sq_packet),
        .commit_count     (commit_count),
        .sent_count       (sent_count),
        .sq_dcache_packet (sq_dcache_packet),
        .dcache_accept    (dcache_accept),
        .ld_query         (ld_query),
        .fwd_result       (fwd_result),
        .head             (head),
        .ready_tail       (ready_tail)
    );

    always #(PERIOD_NS / 2) clock = ~clock;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return (next_rand() >> 8) % n;
    endfunction

    function automatic sq_pkg::mem_func_e rand_func();
        case (rand_below(5))
            0:       return sq_pkg::BYTE;
            1:       return sq_pkg::HALF;
            2:       return sq_pkg::WORD;
            3:       return sq_pkg::BYTEU;
            default: return sq_pkg::HALFU;
        endcase
    endfunction

    function automatic int access_bytes(sq_pkg::mem_func_e func);
        case (func)
            sq_pkg::BYTE, sq_pkg::BYTEU: return 1;
            sq_pkg::HALF, sq_pkg::HALFU: return 2;
            default:                     return 4;
        endcase
    endfunction

    // Naturally aligned address in a small window so stores and loads collide
    function automatic logic [31:0] rand_addr(sq_pkg::mem_func_e func);
        logic [31:0] addr;
        addr = 32'h0000_4000 | 32'(rand_below(8) << 2);
        if (access_bytes(func) == 1) begin
            addr[1:0] = 2'(rand_below(4));
        end else if (access_bytes(func) == 2) begin
            addr[1] = 1'(rand_below(2));
        end
        return addr;
    endfunction

    function automatic logic [3:0] access_mask(sq_pkg::mem_func_e func, logic [1:0] offset);
        logic [3:0] mask;
        mask = '0;
        for (int i = 0; i < access_bytes(func); i++) begin
            if (offset + i < 4) begin
                mask[offset + i] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic sq_pkg::sq_idx_t model_ready_tail();
        sq_pkg::sq_idx_t idx;
        logic            run;
        int              count;
        run   = 1'b1;
        count = 0;
        for (int j = 0; j < `SQ_DEPTH; j++) begin
            idx = m_head + sq_pkg::sq_idx_t'(j);
            run = run && m_valid[idx] && m_ready[idx];
            if (run) begin
                count++;
            end
        end
        return m_head + sq_pkg::sq_idx_t'(count);
    endfunction

    // An older store without an address yet counts as a possible alias
    function automatic sq_pkg::fwd_result_t model_forward(sq_pkg::ld_query_t q);
        sq_pkg::fwd_result_t res;
        sq_pkg::sq_idx_t     idx;
        sq_pkg::sq_idx_t     match;
        logic                stop;
        logic                found;
        logic [3:0]          lmask;
        logic [3:0]          smask;
        logic [3:0]          mmask;
        logic [31:0]         raw;
        int                  pos;
        res   = '0;
        stop  = 1'b0;
        found = 1'b0;
        match = m_head;
        mmask = '0;
        lmask = access_mask(q.func, q.addr[1:0]);
        for (int j = 0; j < `SQ_DEPTH; j++) begin
            idx   = m_head + sq_pkg::sq_idx_t'(j);
            stop  = stop || (idx == q.youngest_older);
            smask = access_mask(m_func[idx], m_addr[idx][1:0]);
            if (!stop && m_valid[idx]) begin
                if (!m_ready[idx] ||
                    (m_addr[idx][31:2] == q.addr[31:2] && (smask & lmask) != 0)) begin
                    found = 1'b1;
                    match = idx;
                    mmask = smask;
                end
            end
        end
        res.hit = found && m_ready[match] && ((lmask & ~mmask) == 4'b0000);
        if (res.hit) begin
            raw = '0;
            for (int i = 0; i < access_bytes(q.func); i++) begin
                pos = q.addr[1:0] + i - m_addr[match][1:0];
                raw[8*i +: 8] = m_data[match][8*pos +: 8];
            end
            case (q.func)
                sq_pkg::BYTE: res.value = {{24{raw[7]}}, raw[7:0]};
                sq_pkg::HALF: res.value = {{16{raw[15]}}, raw[15:0]};
                default:      res.value = raw;
            endcase
        end
        return res;
    endfunction

    task automatic check_dcache(sq_pkg::sq_dcache_packet_t got,
                                sq_pkg::sq_dcache_packet_t exp, string what);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_fwd(sq_pkg::fwd_result_t got, sq_pkg::fwd_result_t exp, string what);
        if (got.hit !== exp.hit || (exp.hit && got.value !== exp.value)) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(sq_pkg::sq_idx_t got, sq_pkg::sq_idx_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(logic [1:0] got, logic [1:0] exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic reset_model();
        m_valid  = '0;
        m_ready  = '0;
        m_head   = '0;
        m_tail   = '0;
        m_size   = 0;
        m_credit = 0;
        m_af     = 1'b0;
        p_valid  = '0;
        for (int e = 0; e < `SQ_DEPTH; e++) begin
            m_func[e] = sq_pkg::BYTE;
            m_addr[e] = '0;
            m_data[e] = '0;
        end
        unfilled.delete();
    endtask

    // Drive on the falling edge, check, then advance the model by one cycle
    task automatic step_cycle();
        sq_pkg::sq_dcache_packet_t exp_pkt;
        sq_pkg::sq_idx_t           idx;
        logic                      present;
        logic                      firing;
        logic [`SQ_DEPTH-1:0]      clear;
        logic [11:0]               imm;
        logic [31:0]               fill_addr [`SQ_STORE_FU];
        int                        pick;
        int                        sent;
        int                        n_alloc;
        int                        uncommitted;
        for (int i = 0; i < `SQ_DISPATCH_W; i++) begin
            id_sq_packet[i].valid = 1'(rand_below(2));
            id_sq_packet[i].func  = rand_func();
        end
        for (int f = 0; f < `SQ_STORE_FU; f++) begin
            rs_sq_packet[f] = '0;
            fill_addr[f]    = '0;
            if (unfilled.size() > 0 && rand_below(2) == 1) begin
                pick = rand_below(unfilled.size());
                idx  = unfilled[pick];
                unfilled.delete(pick);
                imm  = 12'(next_rand());
                fill_addr[f] = rand_addr(m_func[idx]);
                rs_sq_packet[f].valid  = 1'b1;
                rs_sq_packet[f].imm    = imm;
                rs_sq_packet[f].base   = fill_addr[f] - {{20{imm[11]}}, imm};
                rs_sq_packet[f].data   = next_rand();
                rs_sq_packet[f].sq_idx = idx;
            end
        end
        uncommitted  = m_size - m_credit;
        commit_count = 2'(rand_below((uncommitted < 2 ? uncommitted : 2) + 1));
        for (int k = 0; k < `SQ_CACHE_PORTS; k++) begin
            dcache_accept[k] = (rand_below(4) != 0);
        end
        for (int p = 0; p < `SQ_LOAD_PORTS; p++) begin
            ld_query[p].func           = rand_func();
            ld_query[p].addr           = rand_addr(ld_query[p].func);
            ld_query[p].youngest_older = m_head + sq_pkg::sq_idx_t'(rand_below(m_size + 1));
        end
        #1;
        check_idx(head, m_head, "head");
        check_idx(tail, m_tail, "tail");
        check_idx(ready_tail, model_ready_tail(), "ready_tail");
        check_flag(almost_full, m_af, "almost_full");
        present = 1'b1;
        firing  = 1'b1;
        sent    = 0;
        clear   = '0;
        for (int k = 0; k < `SQ_CACHE_PORTS; k++) begin
            idx     = m_head + sq_pkg::sq_idx_t'(k);
            present = present && m_valid[idx] && m_ready[idx] && (m_credit > k);
            exp_pkt = '0;
            if (present) begin
                exp_pkt = '{1'b1, m_addr[idx], m_func[idx], m_data[idx]};
            end
            check_dcache(sq_dcache_packet[k], exp_pkt, $sformatf("dcache port %0d", k));
            firing = firing && present && dcache_accept[k];
            if (firing) begin
                clear[idx] = 1'b1;
                sent++;
            end
        end
        check_count(sent_count, 2'(sent), "sent_count");
        for (int p = 0; p < `SQ_LOAD_PORTS; p++) begin
            check_fwd(fwd_result[p], model_forward(ld_query[p]), $sformatf("fwd port %0d", p));
        end
        // Fills from last cycle land together with drain clears and allocation
        for (int f = 0; f < `SQ_STORE_FU; f++) begin
            if (p_valid[f]) begin
                m_ready[p_idx[f]] = 1'b1;
                m_addr[p_idx[f]]  = p_addr[f];
                m_data[p_idx[f]]  = p_data[f];
            end
        end
        m_valid = m_valid & ~clear;
        m_ready = m_ready & ~clear;
        n_alloc = 0;
        for (int i = 0; i < `SQ_DISPATCH_W; i++) begin
            if (id_sq_packet[i].valid && !m_af) begin
                idx          = m_tail + sq_pkg::sq_idx_t'(n_alloc);
                m_valid[idx] = 1'b1;
                m_ready[idx] = 1'b0;
                m_func[idx]  = id_sq_packet[i].func;
                unfilled.push_back(idx);
                n_alloc++;
            end
        end
        for (int f = 0; f < `SQ_STORE_FU; f++) begin
            p_valid[f] = rs_sq_packet[f].valid;
            p_idx[f]   = rs_sq_packet[f].sq_idx;
            p_addr[f]  = fill_addr[f];
            p_data[f]  = rs_sq_packet[f].data;
        end
        m_head   = m_head + sq_pkg::sq_idx_t'(sent);
        m_tail   = m_tail + sq_pkg::sq_idx_t'(n_alloc);
        m_size   = m_size + n_alloc - sent;
        m_credit = m_credit + commit_count - sent;
        m_af     = (m_size > `SQ_DEPTH - `SQ_DISPATCH_W);
    endtask

    initial begin
        #((NUM_CYCLES + RESET_CYCLES) * PERIOD_NS * 2);
        $display("Timeout: the run did not reach its end in the expected time");
        $display("sim failed");
        $finish;
    end

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        lcg_state     = 32'h7ab122b7;
        errors        = 0;
        id_sq_packet  = '0;
        rs_sq_packet  = '0;
        commit_count  = '0;
        dcache_accept = '0;
        ld_query      = '0;
        reset_model();
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            step_cycle();
            @(negedge clock);
        end
        $display("Run complete after %0d cycles with %0d errors", NUM_CYCLES, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/sq_pkg.sv
verilog/sq_control.sv
verilog/sq_entry_file.sv
verilog/sq_drain.sv
verilog/sq_forward.sv
verilog/store_queue.sv
test/store_queue_tb.sv

// ==== Bender.yml ====
package:
  name: store_queue

export_include_dirs:
  - verilog

sources:
  - verilog/sq_pkg.sv
  - verilog/sq_control.sv
  - verilog/sq_entry_file.sv
  - verilog/sq_drain.sv
  - verilog/sq_forward.sv
  - verilog/store_queue.sv
  - target: test
    files:
      - test/store_queue_tb.sv
